/* src.f */
+incdir+verilog
verilog/periph_pkg.sv
verilog/periph_bus_if.sv
verilog/periph_exti.sv
verilog/periph_gpio.sv
verilog/periph_timer.sv
verilog/periph_uart.sv
verilog/periph_minimal.sv
sim/periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module periph_tb -o periph_sim; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/periph_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* sim/periph_tb.sv */
/* Random-stimulus testbench for the peripheral block with tx looped back to rx.
   Assumes the default window, which ends at address 8'hFF. */
`timescale 1ns/1ns
`include "periph_cfg.svh"

module periph_tb
    import periph_pkg::*;
();

    localparam int UART_FRAME  = 10 * `UART_DIV;
    localparam int TEST_CYCLES = 200 + 8 * 40 + 6 * 80 + 8 * (2 * UART_FRAME + 30) + 300 + 10;
    // 40 ns per cycle plus 20 percent margin.
    localparam int WATCHDOG_NS = TEST_CYCLES * 48;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [7:0]  addr;
    logic [7:0]  data_in;
    logic        write_en;
    logic [15:0] gpi;
    wire  [7:0]  data_out;
    wire  [3:0]  ext_int;
    wire  [15:0] gpo;
    wire         serial_line;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_start_errors;

    // Reference model state.
    logic [15:0] gpo_m, gpie_m, rise_m, gpi_m;
    logic [2:0]  mask_m, pend_m;
    logic        soft_m;
    logic [7:0]  presc_m, reload_m, ctrl_m;

    periph_minimal dut0 (
        .clk(clk), .rst_n(rst_n), .enable(enable), .addr(addr), .data_in(data_in),
        .data_out(data_out), .write_en(write_en), .ext_int(ext_int), .gpi(gpi),
        .gpo(gpo), .rx(serial_line), .tx(serial_line)
    );

    always #20 clk = ~clk;

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, a test did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers.
    function automatic logic [7:0] rand8();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    function automatic logic [7:0] addr_of(input reg_off_e off);
        return `PERIPH_BASE_ADDR + {3'b000, off};
    endfunction

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic bus_write(input logic en, input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        enable   <= en;
        write_en <= 1'b1;
        addr     <= a;
        data_in  <= d;
        @(posedge clk);
        enable   <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic write_reg(input reg_off_e off, input logic [7:0] d);
        bus_write(1'b1, addr_of(off), d);
    endtask

    task automatic bus_read(input logic en, input logic [7:0] a, output logic [7:0] d);
        @(posedge clk);
        enable   <= en;
        write_en <= 1'b0;
        addr     <= a;
        @(negedge clk);
        d = data_out;
        @(posedge clk);
        enable <= 1'b0;
    endtask

    task automatic read_check(input reg_off_e off, input logic [7:0] exp, input string name);
        logic [7:0] d;
        bus_read(1'b1, addr_of(off), d);
        check_value(name, exp, d);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic check_irq_lines();
        @(negedge clk);
        check_value("ext_int", {4'h0, soft_m, pend_m & mask_m}, {4'h0, ext_int});
    endtask

    task automatic set_gpi(input logic [15:0] v);
        @(posedge clk);
        gpi <= v;
        rise_m = rise_m | (v & ~gpi_m);
        if (|(v & ~gpi_m & gpie_m))
            pend_m[0] = 1'b1;
        gpi_m = v;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start_errors)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic verify_regs();
        read_check(EXTI_MASK, {5'b00000, mask_m}, "EXTI_MASK");
        read_check(EXTI_SOFT, {7'b0000000, soft_m}, "EXTI_SOFT");
        read_check(GPO_LO, gpo_m[7:0], "GPO_LO");
        read_check(GPO_HI, gpo_m[15:8], "GPO_HI");
        read_check(GPIE_LO, gpie_m[7:0], "GPIE_LO");
        read_check(GPIE_HI, gpie_m[15:8], "GPIE_HI");
        read_check(TMR_PRESC, presc_m, "TMR_PRESC");
        read_check(TMR_RELOAD, reload_m, "TMR_RELOAD");
        read_check(UART_CTRL, ctrl_m, "UART_CTRL");
        read_check(UART_STAT, 8'h00, "UART_STAT");
        check_value("gpo[7:0]", gpo_m[7:0], gpo[7:0]);
        check_value("gpo[15:8]", gpo_m[15:8], gpo[15:8]);
        check_irq_lines();
    endtask

    ////////////////////////////////////////
    // Test sequence.
    initial
    begin
        logic [7:0] d;
        logic [7:0] r;
        int         k;
        int         n;
        int         polls;

        clk = 1'b0;
        rst_n = 1'b0;
        enable = 1'b0;
        addr = 8'h00;
        data_in = 8'h00;
        write_en = 1'b0;
        gpi = 16'h0000;
        rng_state = 32'ha5a2_de1b;
        errors = 0;
        checks = 0;
        tests = 0;
        test_start_errors = 0;
        gpo_m = '0;
        gpie_m = '0;
        rise_m = '0;
        gpi_m = '0;
        mask_m = '0;
        pend_m = '0;
        soft_m = 1'b0;
        presc_m = '0;
        reload_m = '0;
        ctrl_m = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        idle(2);

        // GPIO data path.
        for (int i = 0; i < 4; i++)
        begin
            gpo_m = {rand8(), rand8()};
            write_reg(GPO_LO, gpo_m[7:0]);
            write_reg(GPO_HI, gpo_m[15:8]);
            read_check(GPO_LO, gpo_m[7:0], "GPO_LO");
            read_check(GPO_HI, gpo_m[15:8], "GPO_HI");
            check_value("gpo[7:0]", gpo_m[7:0], gpo[7:0]);
            check_value("gpo[15:8]", gpo_m[15:8], gpo[15:8]);
            set_gpi({rand8(), rand8()});
            idle(2);
            read_check(GPI_LO, gpi_m[7:0], "GPI_LO");
            read_check(GPI_HI, gpi_m[15:8], "GPI_HI");
        end
        finish_test("gpio_data");

        // GPIO edges into ext_int[0].
        gpie_m = {rand8(), rand8()};
        write_reg(GPIE_LO, gpie_m[7:0]);
        write_reg(GPIE_HI, gpie_m[15:8]);
        write_reg(GPRISE_LO, 8'hff);
        write_reg(GPRISE_HI, 8'hff);
        rise_m = '0;
        mask_m = 3'b001;
        write_reg(EXTI_MASK, 8'h01);
        for (int i = 0; i < 8; i++)
        begin
            set_gpi({rand8(), rand8()});
            idle(3);
            read_check(GPRISE_LO, rise_m[7:0], "GPRISE_LO");
            read_check(GPRISE_HI, rise_m[15:8], "GPRISE_HI");
            read_check(EXTI_PEND, {5'b00000, pend_m}, "EXTI_PEND");
            check_irq_lines();
            r = rand8();
            write_reg(GPRISE_LO, r);
            rise_m[7:0] = rise_m[7:0] & ~r;
            r = rand8();
            write_reg(GPRISE_HI, r);
            rise_m[15:8] = rise_m[15:8] & ~r;
            write_reg(EXTI_PEND, 8'h01);
            pend_m[0] = 1'b0;
            check_irq_lines();
        end
        finish_test("gpio_edges");

        // Timer period and count.
        mask_m = 3'b010;
        write_reg(EXTI_MASK, 8'h02);
        for (int i = 0; i < 6; i++)
        begin
            presc_m = rand8() & 8'h03;
            reload_m = rand8() & 8'h07;
            n = (int'(presc_m) + 1) * (int'(reload_m) + 1);
            write_reg(TMR_PRESC, presc_m);
            write_reg(TMR_RELOAD, reload_m);
            write_reg(EXTI_PEND, 8'h02);
            write_reg(TMR_CTRL, 8'h01);
            k = 0;
            do
            begin
                @(posedge clk);
                k++;
                @(negedge clk);
            end
            while (!ext_int[1] && k <= 64);
            if (k > 64)
            begin
                errors++;
                $display("ERROR: timer interrupt did not arrive");
            end
            else if (k != n)
            begin
                errors++;
                $display("CHECK FAILED timer_delay expected %h got %h", n, k);
            end
            k = k + 1;
            d = 8'(int'(reload_m) - (k / (int'(presc_m) + 1)) % (int'(reload_m) + 1));
            read_check(TMR_CTRL, d, "TMR_CTRL");
            write_reg(TMR_CTRL, 8'h00);
            write_reg(EXTI_PEND, 8'h02);
            pend_m[1] = 1'b0;
            check_irq_lines();
        end
        finish_test("timer");

        // UART loopback for each interrupt setting.
        mask_m = 3'b100;
        write_reg(EXTI_MASK, 8'h04);
        for (int c = 0; c < 8; c++)
        begin
            ctrl_m = 8'(c % 4);
            write_reg(UART_CTRL, ctrl_m);
            write_reg(EXTI_PEND, 8'h04);
            pend_m[2] = 1'b0;
            r = rand8();
            write_reg(UART_TX, r);
            polls = 0;
            do
            begin
                bus_read(1'b1, addr_of(UART_STAT), d);
                // Busy right after the write, nothing received yet.
                if (polls == 0)
                    check_value("UART_STAT", 8'h01, d);
                polls++;
            end
            while (!d[1] && polls < UART_FRAME);
            if (!d[1])
            begin
                errors++;
                $display("ERROR: UART rx-valid was never set");
            end
            read_check(UART_RX, r, "UART_RX");
            // The stop bit may still be going out here.
            bus_read(1'b1, addr_of(UART_STAT), d);
            check_value("UART_STAT[1]", 8'h00, d & 8'h02);
            idle(4);
            read_check(UART_STAT, 8'h00, "UART_STAT");
            pend_m[2] = (ctrl_m != 8'h00);
            check_irq_lines();
        end
        finish_test("uart_loopback");

        // Interrupt controller and window decode.
        mask_m = 3'b111;
        write_reg(EXTI_MASK, 8'h07);
        read_check(EXTI_PEND, {5'b00000, pend_m}, "EXTI_PEND");
        write_reg(EXTI_PEND, 8'h07);
        pend_m = 3'b000;
        read_check(EXTI_PEND, 8'h00, "EXTI_PEND");
        check_irq_lines();
        write_reg(EXTI_SOFT, 8'h01);
        soft_m = 1'b1;
        check_irq_lines();
        read_check(EXTI_SOFT, 8'h01, "EXTI_SOFT");
        write_reg(EXTI_SOFT, 8'h00);
        soft_m = 1'b0;
        check_irq_lines();
        for (int i = 0; i < 6; i++)
        begin
            r = 8'(rand8() % 8'hEE);
            bus_read(1'b1, r, d);
            check_value("data_out", 8'h00, d);
            bus_write(1'b1, r, rand8());
            bus_read(1'b0, addr_of(GPO_LO), d);
            check_value("data_out", 8'h00, d);
            bus_write(1'b0, addr_of(GPO_LO), rand8());
            verify_regs();
        end
        finish_test("exti_decode");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog/periph_minimal.sv */
/* Peripheral window of PERIPH_WINDOW bytes from PERIPH_BASE_ADDR on an 8-bit bus.
   Reads are combinational; writes land on the next rising clock edge. */
`timescale 1ns/1ns
`include "periph_cfg.svh"

module periph_minimal (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  logic [7:0]  addr,
    input  logic [7:0]  data_in,
    output logic [7:0]  data_out,
    input  logic        write_en,
    output logic [3:0]  ext_int,
    input  logic [15:0] gpi,
    output logic [15:0] gpo,
    input  logic        rx,
    output logic        tx
);

    logic [8:0] addr_rel;
    logic [7:0] rd_exti, rd_gpio, rd_timer, rd_uart;
    logic       irq_gpio, irq_timer, irq_uart;

    periph_bus_if bus ();

    ////////////////////////////////////////
    // Window decode.
    // Nine bits so the window may end at the top of the address space.
    assign addr_rel = {1'b0, addr} - {1'b0, `PERIPH_BASE_ADDR};

    assign bus.sel    = enable && (addr_rel < 9'(`PERIPH_WINDOW));
    assign bus.offset = addr_rel[4:0];
    assign bus.wdata  = data_in;
    assign bus.we     = write_en;

    assign data_out = rd_exti | rd_gpio | rd_timer | rd_uart;

    periph_exti u_exti (
        .clk(clk), .rst_n(rst_n), .bus(bus), .rdata(rd_exti),
        .gpio_irq(irq_gpio), .timer_irq(irq_timer), .uart_irq(irq_uart),
        .cpu_int(ext_int)
    );

    periph_gpio u_gpio (
        .clk(clk), .rst_n(rst_n), .bus(bus), .rdata(rd_gpio),
        .irq(irq_gpio), .gpi(gpi), .gpo(gpo)
    );

    periph_timer u_timer (
        .clk(clk), .rst_n(rst_n), .bus(bus), .rdata(rd_timer),
        .irq(irq_timer)
    );

    periph_uart u_uart (
        .clk(clk), .rst_n(rst_n), .bus(bus), .rdata(rd_uart),
        .irq(irq_uart), .rx(rx), .tx(tx)
    );

    // Offsets of the peripherals never overlap.
    a_one_reader: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({|rd_exti, |rd_gpio, |rd_timer, |rd_uart}));

endmodule

/* verilog/periph_uart.sv */
/* 8N1 only, one byte each way, no parity and no framing check.
   A byte received while rx-valid is still set overwrites the old one. */
`timescale 1ns/1ns
`include "periph_cfg.svh"

module periph_uart
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    periph_bus_if.dev  bus,
    output logic [7:0] rdata,
    output logic       irq,
    input  logic       rx,
    output logic       tx
);

    localparam int BCW = $clog2(`UART_DIV);
    localparam logic [BCW-1:0] BIT_LAST = BCW'(`UART_DIV - 1);
    localparam logic [BCW-1:0] BIT_HALF = BCW'(`UART_DIV / 2 - 1);

    uart_state_e    tx_state;
    uart_state_e    rx_state;
    logic [BCW-1:0] tx_baud;
    logic [BCW-1:0] rx_baud;
    logic [2:0]     tx_bit;
    logic [2:0]     rx_bit;
    logic [7:0]     tx_shift;
    logic [7:0]     rx_shift;
    logic [7:0]     rx_data;
    logic           rx_valid;
    logic [1:0]     ctrl_q;
    logic           rx_s1, rx_s2, rx_s3;
    logic           tx_done;
    logic           rx_done;
    logic           wr;
    logic           rx_read;

    assign wr      = bus.sel && bus.we;
    assign rx_read = bus.sel && !bus.we && bus.offset == UART_RX;
    assign tx_done = tx_state == STOP && tx_baud == BIT_LAST;
    assign rx_done = rx_state == STOP && rx_baud == BIT_LAST;

    ////////////////////////////////////////
    // Transmitter.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tx_state <= IDLE;
            tx_baud  <= '0;
            tx_bit   <= 3'd0;
            tx_shift <= 8'h00;
            tx       <= 1'b1;
        end
        else
        begin
            tx_baud <= (tx_state == IDLE || tx_baud == BIT_LAST) ? '0 : tx_baud + 1'b1;
            case (tx_state)
                IDLE:
                    if (wr && bus.offset == UART_TX)
                    begin
                        tx_shift <= bus.wdata;
                        tx       <= 1'b0;
                        tx_state <= START;
                    end
                START:
                    if (tx_baud == BIT_LAST)
                    begin
                        tx       <= tx_shift[0];
                        tx_bit   <= 3'd0;
                        tx_state <= DATA;
                    end
                DATA:
                    if (tx_baud == BIT_LAST)
                    begin
                        tx_shift <= tx_shift >> 1;
                        tx_bit   <= tx_bit + 3'd1;
                        tx       <= (tx_bit == 3'd7) ? 1'b1 : tx_shift[1];
                        if (tx_bit == 3'd7)
                            tx_state <= STOP;
                    end
                STOP:
                    if (tx_done)
                        tx_state <= IDLE;
                default: tx_state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Receiver, sampling at mid-bit.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_s3    <= 1'b1;
            rx_state <= IDLE;
            rx_baud  <= '0;
            rx_bit   <= 3'd0;
            rx_shift <= 8'h00;
            rx_data  <= 8'h00;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_s3 <= rx_s2;
            rx_baud <= (rx_state == IDLE || rx_baud == BIT_LAST) ? '0 : rx_baud + 1'b1;
            if (rx_read)
                rx_valid <= 1'b0;
            case (rx_state)
                IDLE:
                    if (rx_s3 && !rx_s2)
                        rx_state <= START;
                START:
                    // Half a bit in, so later samples land mid-bit.
                    if (rx_baud == BIT_HALF)
                    begin
                        rx_baud  <= '0;
                        rx_bit   <= 3'd0;
                        rx_state <= rx_s2 ? IDLE : DATA;
                    end
                DATA:
                    if (rx_baud == BIT_LAST)
                    begin
                        rx_shift <= {rx_s2, rx_shift[7:1]};
                        rx_bit   <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7)
                            rx_state <= STOP;
                    end
                STOP:
                    if (rx_done)
                    begin
                        rx_data  <= rx_shift;
                        rx_valid <= 1'b1;
                        rx_state <= IDLE;
                    end
                default: rx_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctrl_q <= 2'b00;
            irq    <= 1'b0;
        end
        else
        begin
            if (wr && bus.offset == UART_CTRL)
                ctrl_q <= bus.wdata[1:0];
            irq <= (rx_done && ctrl_q[0]) || (tx_done && ctrl_q[1]);
        end
    end

    always_comb
    begin
        rdata = 8'h00;
        if (bus.sel)
        begin
            case (bus.offset)
                UART_RX:   rdata = rx_data;
                UART_STAT: rdata = {6'b000000, rx_valid, tx_state != IDLE};
                UART_CTRL: rdata = {6'b000000, ctrl_q};
                default:   rdata = 8'h00;
            endcase
        end
    end

    // Line must idle high between frames.
    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        tx_state == IDLE |-> tx);

endmodule

/* verilog/periph_timer.sv */
/* Writing TMR_CTRL bit 0 as 1 (re)starts from the reload value, 0 stops.
   PRESC = 0 with RELOAD = 0 strobes irq on every clock. */
`timescale 1ns/1ns

module periph_timer
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    periph_bus_if.dev  bus,
    output logic [7:0] rdata,
    output logic       irq
);

    logic [7:0] presc_q;
    logic [7:0] reload_q;
    logic [7:0] pcnt_q;
    logic [7:0] cnt_q;
    logic       run_q;
    logic       wr;
    logic       ctrl_wr;
    logic       tick;

    assign wr      = bus.sel && bus.we;
    assign ctrl_wr = wr && bus.offset == TMR_CTRL;

    // Compare with >= so a smaller PRESC written mid-count takes effect at once.
    assign tick = run_q && (pcnt_q >= presc_q);
    assign irq  = tick && (cnt_q == 8'h00) && !ctrl_wr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            presc_q  <= 8'h00;
            reload_q <= 8'h00;
            pcnt_q   <= 8'h00;
            cnt_q    <= 8'h00;
            run_q    <= 1'b0;
        end
        else
        begin
            if (wr && bus.offset == TMR_PRESC)
                presc_q <= bus.wdata;
            if (wr && bus.offset == TMR_RELOAD)
                reload_q <= bus.wdata;

            if (ctrl_wr)
            begin
                run_q <= bus.wdata[0];
                if (bus.wdata[0])
                begin
                    cnt_q  <= reload_q;
                    pcnt_q <= 8'h00;
                end
            end
            else if (tick)
            begin
                pcnt_q <= 8'h00;
                cnt_q  <= (cnt_q == 8'h00) ? reload_q : cnt_q - 8'd1;
            end
            else if (run_q)
                pcnt_q <= pcnt_q + 8'd1;
        end
    end

    always_comb
    begin
        rdata = 8'h00;
        if (bus.sel)
        begin
            case (bus.offset)
                TMR_PRESC:  rdata = presc_q;
                TMR_RELOAD: rdata = reload_q;
                TMR_CTRL:   rdata = cnt_q;
                default:    rdata = 8'h00;
            endcase
        end
    end

    ////////////////////////////////////////
    // Strobe stays single unless the period is one clock.
    a_irq_single: assert property (@(posedge clk) disable iff (!rst_n)
        irq && !(presc_q == 8'h00 && reload_q == 8'h00) |=> !irq);

endmodule

/* verilog/periph_gpio.sv */
/* 16 inputs sampled by one flop, no synchronizer beyond that.
   GPI reads return the sampled value, not the raw pins. */
`timescale 1ns/1ns

module periph_gpio
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    periph_bus_if.dev   bus,
    output logic [7:0]  rdata,
    output logic        irq,
    input  logic [15:0] gpi,
    output logic [15:0] gpo
);

    logic [15:0] gpo_q;
    logic [15:0] gpie_q;
    logic [15:0] gpi_q;
    logic [15:0] rise_q;
    logic [15:0] rise_now;
    logic [15:0] rise_clr;
    logic        wr;

    assign wr = bus.sel && bus.we;

    // Input low in the last sample, high now.
    assign rise_now = gpi & ~gpi_q;

    always_comb
    begin
        rise_clr = 16'h0000;
        if (wr && bus.offset == GPRISE_LO)
            rise_clr[7:0] = bus.wdata;
        if (wr && bus.offset == GPRISE_HI)
            rise_clr[15:8] = bus.wdata;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gpo_q  <= 16'h0000;
            gpie_q <= 16'h0000;
            gpi_q  <= 16'h0000;
            rise_q <= 16'h0000;
            irq    <= 1'b0;
        end
        else
        begin
            gpi_q  <= gpi;
            rise_q <= (rise_q & ~rise_clr) | rise_now;
            irq    <= |(rise_now & gpie_q);
            if (wr)
            begin
                case (bus.offset)
                    GPO_LO:  gpo_q[7:0]   <= bus.wdata;
                    GPO_HI:  gpo_q[15:8]  <= bus.wdata;
                    GPIE_LO: gpie_q[7:0]  <= bus.wdata;
                    GPIE_HI: gpie_q[15:8] <= bus.wdata;
                    default: ;
                endcase
            end
        end
    end

    assign gpo = gpo_q;

    always_comb
    begin
        rdata = 8'h00;
        if (bus.sel)
        begin
            case (bus.offset)
                GPI_LO:    rdata = gpi_q[7:0];
                GPI_HI:    rdata = gpi_q[15:8];
                GPO_LO:    rdata = gpo_q[7:0];
                GPO_HI:    rdata = gpo_q[15:8];
                GPIE_LO:   rdata = gpie_q[7:0];
                GPIE_HI:   rdata = gpie_q[15:8];
                GPRISE_LO: rdata = rise_q[7:0];
                GPRISE_HI: rdata = rise_q[15:8];
                default:   rdata = 8'h00;
            endcase
        end
    end

endmodule

/* verilog/periph_exti.sv */
/* Interrupt lines: 0 gpio, 1 timer, 2 uart, 3 software bit.
   A strobe arriving with a clear in the same cycle keeps the bit pending. */
`timescale 1ns/1ns

module periph_exti
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    periph_bus_if.dev  bus,
    output logic [7:0] rdata,
    input  logic       gpio_irq,
    input  logic       timer_irq,
    input  logic       uart_irq,
    output logic [3:0] cpu_int
);

    logic [2:0] mask_q;
    logic [2:0] pend_q;
    logic       soft_q;
    logic [2:0] src;
    logic       wr;

    assign src = {uart_irq, timer_irq, gpio_irq};
    assign wr  = bus.sel && bus.we;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mask_q <= 3'b000;
            pend_q <= 3'b000;
            soft_q <= 1'b0;
        end
        else
        begin
            if (wr && bus.offset == EXTI_MASK)
                mask_q <= bus.wdata[2:0];
            if (wr && bus.offset == EXTI_SOFT)
                soft_q <= bus.wdata[0];
            // New strobes win over a clear.
            if (wr && bus.offset == EXTI_PEND)
                pend_q <= (pend_q & ~bus.wdata[2:0]) | src;
            else
                pend_q <= pend_q | src;
        end
    end

    assign cpu_int = {soft_q, pend_q & mask_q};

    always_comb
    begin
        rdata = 8'h00;
        if (bus.sel)
        begin
            case (bus.offset)
                EXTI_MASK: rdata = {5'b00000, mask_q};
                EXTI_PEND: rdata = {5'b00000, pend_q};
                EXTI_SOFT: rdata = {7'b0000000, soft_q};
                default:   rdata = 8'h00;
            endcase
        end
    end

    // Pending only rises after a strobe one cycle earlier.
    a_pend_needs_src: assert property (@(posedge clk) disable iff (!rst_n)
        (pend_q & ~$past(pend_q) & ~$past(src)) == 3'b000);

endmodule

/* verilog/periph_bus_if.sv */
/* Decoded bus access inside the block. sel already includes the window check,
   so a peripheral only compares the offset. */
`timescale 1ns/1ns

interface periph_bus_if;

    logic       sel;
    logic [4:0] offset;
    logic [7:0] wdata;
    logic       we;

    // Address decoder side.
    modport host (
        output sel, offset, wdata, we
    );

    // Peripheral side.
    modport dev (
        input sel, offset, wdata, we
    );

endinterface

/* verilog/periph_pkg.sv */
/* Register map and UART state encoding shared by all peripherals.
   Offsets are relative to the window base. */

package periph_pkg;

    // Register offsets inside the window.
    typedef enum logic [4:0] {
        EXTI_MASK  = 5'd0,
        EXTI_PEND  = 5'd1,
        EXTI_SOFT  = 5'd2,
        GPI_LO     = 5'd3,
        GPI_HI     = 5'd4,
        GPO_LO     = 5'd5,
        GPO_HI     = 5'd6,
        GPIE_LO    = 5'd7,
        GPIE_HI    = 5'd8,
        GPRISE_LO  = 5'd9,
        GPRISE_HI  = 5'd10,
        TMR_PRESC  = 5'd11,
        TMR_RELOAD = 5'd12,
        TMR_CTRL   = 5'd13,
        UART_TX    = 5'd14,
        UART_RX    = 5'd15,
        UART_STAT  = 5'd16,
        UART_CTRL  = 5'd17
    } reg_off_e;

    // Shared by the transmit and the receive machine.
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

endpackage

/* verilog/periph_cfg.svh */
/* Build-time settings of the peripheral block. UART_DIV must come out as a
   whole number of at least 4 clocks per bit. The window must fit in 5 bits. */

`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// First bus address of the peripheral window.
`define PERIPH_BASE_ADDR 8'hEE

// Number of byte registers in the window.
`define PERIPH_WINDOW 18

// System clock in Hz.
`define CLK_FREQ 1000000

// Fixed UART line rate.
`define UART_BAUD 62500

// Clocks per UART bit.
`define UART_DIV (`CLK_FREQ / `UART_BAUD)

`endif
